//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

    // --------------------
    // address map
    // --------------------

    // the region field sits in address bits 31:24, so the width is fixed here.
    localparam int XLEN = 32;

    localparam logic [7:0] REGION_IRAM = 8'h00;
    localparam logic [7:0] REGION_DRAM = 8'h10;

    // --------------------
    // data types
    // --------------------

    // one memory word, seen either whole or as four bytes with byte 0 lowest.
    typedef union packed {
        logic [XLEN-1:0]  word;
        logic [3:0][7:0]  bytes;
    } mem_word_u;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        mem_word_u       data;
        logic [3:0]      byte_en;
    } mem_wr_t;

    typedef struct packed {
        logic      valid;
        mem_word_u data;
    } mem_rd_t;

    // payload is a start address when is_addr is set, otherwise a byte in 7:0.
    typedef struct packed {
        logic            is_addr;
        logic [XLEN-1:0] payload;
    } load_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK_WAIT
    } load_state_e;

endpackage

`default_nettype wire

//--- byte_lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram #(
    parameter int DEPTH_LOG2 = 10
) (
    input  logic                  clk_i,
    input  logic                  wr_en_i,
    input  logic [DEPTH_LOG2-1:0] wr_addr_i,
    input  logic [7:0]            wr_data_i,
    input  logic                  rd_en_i,
    input  logic [DEPTH_LOG2-1:0] rd_addr_i,
    output logic [7:0]            rd_data_o
);

    logic [7:0] mem [2**DEPTH_LOG2];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read-first on a same-cycle collision, and the output holds while disabled.
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // an unknown write address would corrupt an unknown location.
    a_wr_addr_known: assert property (
        @(posedge clk_i) wr_en_i |-> !$isunknown(wr_addr_i)
    ) else $error("byte_lane_ram: write enabled with unknown address %h", wr_addr_i);

endmodule

`default_nettype wire

//--- unaligned_ram.sv
`timescale 1ns/1ps
`default_nettype none

module unaligned_ram import mem_pkg::*; #(
    parameter int         DEPTH_LOG2 = 10,
    parameter logic [7:0] REGION     = REGION_IRAM
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] rd_addr_i,
    output mem_rd_t         rd_o,
    input  mem_wr_t         wr_i
);

    // --------------------
    // region decode
    // --------------------

    logic rd_hit;
    logic wr_hit;

    assign rd_hit = (rd_addr_i[XLEN-1:XLEN-8] == REGION);
    assign wr_hit = (wr_i.addr[XLEN-1:XLEN-8] == REGION);

    // --------------------
    // word addresses
    // --------------------

    // an access starting at byte offset k touches word a in lanes k..3 and
    // word a+1 in lanes 0..k-1.
    logic [1:0]            rd_off;
    logic [1:0]            wr_off;
    logic [DEPTH_LOG2-1:0] rd_word_a;
    logic [DEPTH_LOG2-1:0] rd_word_b;
    logic [DEPTH_LOG2-1:0] wr_word_a;
    logic [DEPTH_LOG2-1:0] wr_word_b;

    assign rd_off    = rd_addr_i[1:0];
    assign wr_off    = wr_i.addr[1:0];
    assign rd_word_a = rd_addr_i[DEPTH_LOG2+1:2];
    assign rd_word_b = rd_word_a + 1'b1;
    assign wr_word_a = wr_i.addr[DEPTH_LOG2+1:2];
    assign wr_word_b = wr_word_a + 1'b1;

    // --------------------
    // lane steering
    // --------------------

    logic [3:0][DEPTH_LOG2-1:0] rd_lane_addr;
    logic [3:0][DEPTH_LOG2-1:0] wr_lane_addr;
    logic [3:0][7:0]            wr_lane_data;
    logic [3:0]                 wr_lane_en;
    logic [3:0][7:0]            lane_rd_data;

    always_comb begin
        for (int l = 0; l < 4; l++) begin
            if (l < int'(rd_off)) begin
                rd_lane_addr[l] = rd_word_b;
            end else begin
                rd_lane_addr[l] = rd_word_a;
            end
        end
    end

    // lane l stores word byte (l - offset) mod 4.
    always_comb begin
        logic [1:0] src;
        for (int l = 0; l < 4; l++) begin
            src = 2'(l) - wr_off;
            if (l < int'(wr_off)) begin
                wr_lane_addr[l] = wr_word_b;
            end else begin
                wr_lane_addr[l] = wr_word_a;
            end
            wr_lane_data[l] = wr_i.data.bytes[src];
            wr_lane_en[l]   = wr_hit && wr_i.byte_en[src];
        end
    end

    // --------------------
    // byte lanes
    // --------------------

    for (genvar g = 0; g < 4; g++) begin : g_lane
        byte_lane_ram #(
            .DEPTH_LOG2 (DEPTH_LOG2)
        ) u_lane (
            .clk_i     (clk_i),
            .wr_en_i   (wr_lane_en[g]),
            .wr_addr_i (wr_lane_addr[g]),
            .wr_data_i (wr_lane_data[g]),
            .rd_en_i   (rd_hit),
            .rd_addr_i (rd_lane_addr[g]),
            .rd_data_o (lane_rd_data[g])
        );
    end

    // --------------------
    // read return
    // --------------------

    // the offset and hit travel alongside the one-cycle lane read.
    logic [1:0] rd_off_q;
    logic       rd_hit_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_off_q <= 2'b00;
            rd_hit_q <= 1'b0;
        end else begin
            rd_off_q <= rd_off;
            rd_hit_q <= rd_hit;
        end
    end

    // word byte k comes back from lane (k + offset) mod 4.
    mem_word_u rd_word;

    always_comb begin
        logic [1:0] lane;
        for (int k = 0; k < 4; k++) begin
            lane             = 2'(k) + rd_off_q;
            rd_word.bytes[k] = lane_rd_data[lane];
        end
    end

    assign rd_o.valid = rd_hit_q;
    assign rd_o.data  = rd_hit_q ? rd_word : mem_word_u'('0);

    // a write that misses this region is dropped here; flag it for the system.
    a_wr_in_region: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !wr_hit |=> ($past(wr_i.byte_en) == 4'b0000)
    ) else $warning("unaligned_ram %h: write to %h outside region was ignored",
                    REGION, $past(wr_i.addr));

endmodule

`default_nettype wire

//--- load_addr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module load_addr_counter import mem_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            load_i,
    input  logic [XLEN-1:0] start_addr_i,
    input  logic            step_i,
    output logic [XLEN-1:0] addr_o
);

    // the full address increments, so bytes walk lanes 0 to 3 and then carry
    // into the next word and, past the end, into the next region.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_o <= '0;
        end else if (load_i) begin
            addr_o <= start_addr_i;
        end else if (step_i) begin
            addr_o <= addr_o + 1'b1;
        end
    end

    // the FSM issues either an address load or a byte step in one EXEC cycle.
    a_load_step_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(load_i && step_i)
    ) else $error("load_addr_counter: load and step requested together");

endmodule

`default_nettype wire

//--- load_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module load_fsm import mem_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      load_req_i,
    input  load_cmd_t load_cmd_i,
    output logic      load_ack_o,
    output logic      load_busy_o,
    output logic      cnt_load_o,
    output logic      cnt_step_o,
    output logic [7:0] wr_byte_o
);

    load_state_e state_q;
    load_state_e state_d;

    // --------------------
    // next state
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (load_req_i) begin
                    state_d = EXEC;
                end
            end
            EXEC: begin
                state_d = ACK_WAIT;
            end
            ACK_WAIT: begin
                // hold ack until the host drops req.
                if (!load_req_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // --------------------
    // state and ack
    // --------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            load_ack_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            load_ack_o <= (state_d == ACK_WAIT);
        end
    end

    // --------------------
    // command execution
    // --------------------

    // the host holds the command stable until ack, so EXEC decodes it directly.
    assign load_busy_o = (state_q == EXEC) && !load_cmd_i.is_addr;
    assign cnt_load_o  = (state_q == EXEC) && load_cmd_i.is_addr;
    assign cnt_step_o  = load_busy_o;
    assign wr_byte_o   = load_cmd_i.payload[7:0];

    // ack may only answer a request the host was still holding at the edge that raised it.
    a_ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(load_ack_o) |-> $past(load_req_i)
    ) else $error("load_fsm: ack raised while req is low");

endmodule

`default_nettype wire

//--- mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; #(
    parameter int DEPTH_LOG2 = 10
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] iram_rd_addr_i,
    input  logic [XLEN-1:0] dram_rd_addr_i,
    input  mem_wr_t         dram_wr_i,
    output mem_rd_t         iram_rd_o,
    output mem_rd_t         dram_rd_o,
    input  logic            load_req_i,
    input  load_cmd_t       load_cmd_i,
    output logic            load_ack_o,
    output logic            load_busy_o
);

    logic            cnt_load;
    logic            cnt_step;
    logic [7:0]      wr_byte;
    logic [XLEN-1:0] load_addr;
    mem_wr_t         loader_wr;
    mem_wr_t         iram_wr;
    mem_wr_t         dram_wr;
    logic [XLEN-1:0] iram_rd_addr;
    logic [XLEN-1:0] dram_rd_addr;
    load_state_e     fsm_state;

    // --------------------
    // loader
    // --------------------

    load_fsm u_load_fsm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_req_i  (load_req_i),
        .load_cmd_i  (load_cmd_i),
        .load_ack_o  (load_ack_o),
        .load_busy_o (load_busy_o),
        .cnt_load_o  (cnt_load),
        .cnt_step_o  (cnt_step),
        .wr_byte_o   (wr_byte)
    );

    load_addr_counter u_load_addr_counter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_i       (cnt_load),
        .start_addr_i (load_cmd_i.payload),
        .step_i       (cnt_step),
        .addr_o       (load_addr)
    );

    // the byte goes to every lane and byte_en 0001 is rotated to the right one.
    always_comb begin
        loader_wr.addr      = load_addr;
        loader_wr.data.word = {4{wr_byte}};
        loader_wr.byte_en   = 4'b0001;
    end

    // --------------------
    // port mux
    // --------------------

    // while the loader writes, it owns both RAMs and any core write is lost.
    always_comb begin
        if (load_busy_o) begin
            iram_rd_addr = load_addr;
            dram_rd_addr = load_addr;
            iram_wr      = loader_wr;
            dram_wr      = loader_wr;
        end else begin
            iram_rd_addr = iram_rd_addr_i;
            dram_rd_addr = dram_rd_addr_i;
            iram_wr      = '0;
            dram_wr      = dram_wr_i;
        end
    end

    unaligned_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .REGION     (REGION_IRAM)
    ) u_iram (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd_addr_i (iram_rd_addr),
        .rd_o      (iram_rd_o),
        .wr_i      (iram_wr)
    );

    unaligned_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .REGION     (REGION_DRAM)
    ) u_dram (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd_addr_i (dram_rd_addr),
        .rd_o      (dram_rd_o),
        .wr_i      (dram_wr)
    );

    // --------------------
    // loader checks
    // --------------------

    assign fsm_state = u_load_fsm.state_q;

    // EXEC takes the byte and the start address straight from the command port.
    a_exec_cmd_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (fsm_state == EXEC) |-> (load_req_i && $stable(load_cmd_i))
    ) else $error("mem_subsys_top: load command changed before it was executed");

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam int ACK_TIMEOUT = 20;

    logic            clk_i;
    logic            rst_n_i;
    logic [XLEN-1:0] iram_rd_addr_i;
    logic [XLEN-1:0] dram_rd_addr_i;
    mem_wr_t         dram_wr_i;
    mem_rd_t         iram_rd_o;
    mem_rd_t         dram_rd_o;
    logic            load_req_i;
    load_cmd_t       load_cmd_i;
    logic            load_ack_o;
    logic            load_busy_o;

    mem_subsys_top #(
        .DEPTH_LOG2 (10)
    ) UUT (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .iram_rd_addr_i (iram_rd_addr_i),
        .dram_rd_addr_i (dram_rd_addr_i),
        .dram_wr_i      (dram_wr_i),
        .iram_rd_o      (iram_rd_o),
        .dram_rd_o      (dram_rd_o),
        .load_req_i     (load_req_i),
        .load_cmd_i     (load_cmd_i),
        .load_ack_o     (load_ack_o),
        .load_busy_o    (load_busy_o)
    );

    always #50 clk_i = ~clk_i;

    // --------------------
    // checks
    // --------------------

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rd(input mem_rd_t act, input mem_rd_t exp, input string name);
        if (act !== exp) begin
            $display("ERROR: time %0t, %s: got valid=%b data=%h, expected valid=%b data=%h",
                     $time, name, act.valid, act.data.word, exp.valid, exp.data.word);
            abort_run();
        end
    endtask

    task automatic check_ack(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("ERROR: time %0t, %s: got %b, expected %b", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic report_bad_line(input logic [7:0] op);
        $display("the stimulus file holds a malformed or unknown line with opcode '%c'", op);
        abort_run();
    endtask

    // --------------------
    // bus operations
    // --------------------

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (load_ack_o !== level) begin
            if (cycles == ACK_TIMEOUT) begin
                $display("load_ack_o did not go to %b within %0d cycles", level, ACK_TIMEOUT);
                abort_run();
            end
            @(negedge clk_i);
            cycles++;
        end
    endtask

    task automatic host_load(input load_cmd_t cmd);
        @(negedge clk_i);
        check_ack(load_ack_o, 1'b0, "load_ack_o");
        load_cmd_i = cmd;
        load_req_i = 1'b1;
        // the FSM executes the command in the cycle after it samples req.
        @(negedge clk_i);
        check_ack(load_busy_o, !cmd.is_addr, "load_busy_o");
        wait_ack(1'b1);
        load_req_i = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic core_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                              input logic [3:0] byte_en);
        @(negedge clk_i);
        dram_wr_i.addr      = addr;
        dram_wr_i.data.word = data;
        dram_wr_i.byte_en   = byte_en;
        @(negedge clk_i);
        dram_wr_i.byte_en = 4'b0000;
    endtask

    task automatic read_check(input logic is_iram, input logic [XLEN-1:0] addr,
                              input logic valid, input logic [XLEN-1:0] word);
        mem_rd_t exp;
        @(negedge clk_i);
        if (is_iram) begin
            iram_rd_addr_i = addr;
        end else begin
            dram_rd_addr_i = addr;
        end
        exp.valid     = valid;
        exp.data.word = word;
        @(negedge clk_i);
        if (is_iram) begin
            check_rd(iram_rd_o, exp, "iram_rd_o");
        end else begin
            check_rd(dram_rd_o, exp, "dram_rd_o");
        end
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        int                fd;
        int                fields;
        logic [7:0]        op;
        logic [XLEN-1:0]   arg0;
        logic [XLEN-1:0]   arg1;
        logic [XLEN-1:0]   arg2;
        logic [8*128-1:0]  line;
        load_cmd_t         cmd;
        mem_rd_t           idle_rd;

        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        // both read ports point into their own regions, so only reset keeps valid low.
        iram_rd_addr_i = 32'h0000_0000;
        dram_rd_addr_i = 32'h1000_0000;
        dram_wr_i      = '{addr: 32'h1000_0000, data: '0, byte_en: 4'b0000};
        load_req_i     = 1'b0;
        load_cmd_i     = '0;
        idle_rd        = '0;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        check_rd(iram_rd_o, idle_rd, "iram_rd_o");
        check_rd(dram_rd_o, idle_rd, "dram_rd_o");
        check_ack(load_ack_o, 1'b0, "load_ack_o");
        check_ack(load_busy_o, 1'b0, "load_busy_o");
        rst_n_i = 1'b1;

        fd = $fopen("tb_mem_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb_mem_stim.txt");
            abort_run();
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": begin
                    fields = $fgets(line, fd);
                end
                "A", "B": begin
                    fields = $fscanf(fd, "%h", arg0);
                    if (fields != 1) begin
                        report_bad_line(op);
                    end
                    cmd.is_addr = (op == "A");
                    cmd.payload = arg0;
                    host_load(cmd);
                end
                "W": begin
                    fields = $fscanf(fd, "%h %h %h", arg0, arg1, arg2);
                    if (fields != 3) begin
                        report_bad_line(op);
                    end
                    core_write(arg0, arg1, arg2[3:0]);
                end
                "I", "D": begin
                    fields = $fscanf(fd, "%h %h %h", arg0, arg1, arg2);
                    if (fields != 3) begin
                        report_bad_line(op);
                    end
                    read_check(op == "I", arg0, arg1[0], arg2);
                end
                default: begin
                    report_bad_line(op);
                end
            endcase
        end
        $fclose(fd);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
mem_pkg.sv
byte_lane_ram.sv
unaligned_ram.sv
load_addr_counter.sv
load_fsm.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- tb_mem_stim.txt
# A addr: load address command    B byte: load byte command    W addr data byte_en: core write
# I/D addr valid word: read the instruction or data RAM and expect valid and word (all hex)
# the loader fills the instruction RAM from address 0.
A 00000000
B 11
B 22
B 33
B 44
B 55
B 66
B 77
B 88
I 00000000 1 44332211
I 00000004 1 88776655
I 00000001 1 55443322
I 00000002 1 66554433
I 00000003 1 77665544
# a new start address moves the loader into the data RAM.
A 10000010
B a0
B a1
B a2
B a3
B a4
B a5
B a6
B a7
D 10000010 1 a3a2a1a0
D 10000014 1 a7a6a5a4
# offset 3 with byte_en 0101 writes 0x13 and 0x15 only.
W 10000013 c4c3c2c1 5
D 10000010 1 c1a2a1a0
D 10000011 1 a4c1a2a1
D 10000013 1 a6c3a4c1
D 10000014 1 a7a6c3a4
# regions other than 0x00 and 0x10 miss, and so does the wrong port.
I 20000000 0 00000000
D 30000004 0 00000000
D 00000000 0 00000000
I 10000010 0 00000000
